// File: common/rv32m_pkg.sv
// Shared definitions for the RV32M multiply/divide unit
// Word width, word type, operation encoding
// Special-case result constants for divide by zero and signed overflow

package rv32m_pkg;

    // Machine word width
    parameter int XLEN = 32;

    // One operand or result word
    typedef logic [XLEN-1:0] word_t;

    // M extension operations
    // Top bit set marks the divide class
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } rv32m_op_t;

    // Quotient on divide by zero for signed and unsigned division
    parameter word_t DIV_ZERO_QUOTIENT = {XLEN{1'b1}};

    // Most negative signed word
    // Overflow quotient and dividend half of the overflow test
    parameter word_t SIGNED_MIN = {1'b1, {(XLEN-1){1'b0}}};

endpackage

// File: hw/rv32m_request.sv
// Request stage of the RV32M unit
// Saved copy of the last accepted request, new request detection,
// effective operands and per-operand signedness decode

module rv32m_request (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                start,
    input  rv32m_pkg::rv32m_op_t op,
    input  rv32m_pkg::word_t    a,
    input  rv32m_pkg::word_t    b,
    output logic                new_req,
    output rv32m_pkg::word_t    opa,
    output rv32m_pkg::word_t    opb,
    output logic                sign_a,
    output logic                sign_b
);

    // Last request seen with start high
    rv32m_pkg::rv32m_op_t op_save;
    rv32m_pkg::word_t     a_save;
    rv32m_pkg::word_t     b_save;

    // Any field differs from the saved copy
    assign new_req = start && ((op != op_save) || (a != a_save) || (b != b_save));

    // Held request operands equal the saved copy
    assign opa = a;
    assign opb = b;

    // Saved state after reset looks like MUL 0 x 0
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            op_save <= rv32m_pkg::MUL;
            a_save  <= '0;
            b_save  <= '0;
        end else if (new_req) begin
            op_save <= op;
            a_save  <= a;
            b_save  <= b;
        end
    end

    // Operand signedness per operation
    always_comb begin
        case (op)
            // Signed by unsigned high word
            rv32m_pkg::MULHSU: begin
                sign_a = 1'b1;
                sign_b = 1'b0;
            end
            rv32m_pkg::MULHU, rv32m_pkg::DIVU, rv32m_pkg::REMU: begin
                sign_a = 1'b0;
                sign_b = 1'b0;
            end
            // MUL, MULH, DIV and REM
            default: begin
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
        endcase
    end

endmodule

// File: hw/mul/shift_add_mul32.sv
// Iterative shift-add multiplier
// Magnitude multiply, one multiplier bit per cycle over WIDTH cycles,
// sign fix-up folded into the last step

module shift_add_mul32 #(
    parameter int WIDTH = 32
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 start,
    input  logic [WIDTH-1:0]     multiplicand,
    input  logic [WIDTH-1:0]     multiplier,
    input  logic                 sign_a,
    input  logic                 sign_b,
    output logic                 done,
    output logic [2*WIDTH-1:0]   product
);

    localparam int CNT_W = $clog2(WIDTH);

    // Operand magnitudes and product sign at load time
    logic                 neg_a;
    logic                 neg_b;
    logic [WIDTH-1:0]     mag_a;
    logic [WIDTH-1:0]     mag_b;

    // Working registers
    logic [WIDTH-1:0]     mcand_q;
    logic [2*WIDTH-1:0]   prod_q;
    logic                 neg_q;

    // One iteration
    logic [WIDTH:0]       upper_sum;
    logic [2*WIDTH-1:0]   prod_step;

    // Iteration control
    logic                 running;
    logic [CNT_W-1:0]     count;
    logic                 last_step;

    assign neg_a = sign_a && multiplicand[WIDTH-1];
    assign neg_b = sign_b && multiplier[WIDTH-1];

    // Most negative value keeps its bit pattern, which is the right magnitude
    assign mag_a = neg_a ? -multiplicand : multiplicand;
    assign mag_b = neg_b ? -multiplier : multiplier;

    // Add multiplicand into the upper half when the current low bit is set
    assign upper_sum = {1'b0, prod_q[2*WIDTH-1:WIDTH]}
                     + (prod_q[0] ? {1'b0, mcand_q} : {(WIDTH+1){1'b0}});

    // Shift right, carry enters at the top
    assign prod_step = {upper_sum, prod_q[WIDTH-1:1]};

    assign last_step = running && (count == '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            done    <= 1'b0;
            count   <= CNT_W'(WIDTH - 1);
        end else if (running) begin
            if (last_step) begin
                running <= 1'b0;
                // Held until the next start
                done    <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            mcand_q <= mag_a;
            // Low half holds the multiplier bits still to be consumed
            prod_q  <= {{WIDTH{1'b0}}, mag_b};
            neg_q   <= neg_a ^ neg_b;
        end else if (running) begin
            // Negate on the way out for a negative product
            prod_q <= (last_step && neg_q) ? -prod_step : prod_step;
        end
    end

    assign product = prod_q;

endmodule

// File: hw/div/restoring_div32.sv
// Iterative restoring divider
// Magnitude divide, one quotient bit per cycle over WIDTH cycles,
// quotient and remainder sign fix-up on the last step

module restoring_div32 #(
    parameter int WIDTH = 32
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               start,
    input  logic [WIDTH-1:0]   dividend,
    input  logic [WIDTH-1:0]   divisor,
    input  logic               is_signed,
    output logic               done,
    output logic [WIDTH-1:0]   quotient,
    output logic [WIDTH-1:0]   remainder
);

    localparam int CNT_W = $clog2(WIDTH);

    // Operand signs and magnitudes
    logic               neg_dvd;
    logic               neg_dvs;
    logic [WIDTH-1:0]   mag_dvd;
    logic [WIDTH-1:0]   mag_dvs;

    // Working registers
    // quo_q starts as the dividend and fills with quotient bits from the right
    logic [WIDTH-1:0]   quo_q;
    logic [WIDTH-1:0]   rem_q;
    logic [WIDTH-1:0]   dvs_q;
    logic               neg_quo_q;
    logic               neg_rem_q;

    // One restoring step
    logic [WIDTH:0]     shifted;
    logic [WIDTH+1:0]   diff;
    logic               fits;
    logic [WIDTH-1:0]   rem_next;
    logic [WIDTH-1:0]   quo_next;

    // Iteration control
    logic               running;
    logic [CNT_W-1:0]   count;
    logic               last_step;

    assign neg_dvd = is_signed && dividend[WIDTH-1];
    assign neg_dvs = is_signed && divisor[WIDTH-1];
    assign mag_dvd = neg_dvd ? -dividend : dividend;
    assign mag_dvs = neg_dvs ? -divisor : divisor;

    // Bring down the next dividend bit
    assign shifted = {rem_q, quo_q[WIDTH-1]};

    // Trial subtract, extra top bit is the borrow
    assign diff = {1'b0, shifted} - {2'b00, dvs_q};
    assign fits = !diff[WIDTH+1];

    // Keep the difference only when it did not go negative
    // Either way the partial remainder is below the divisor
    assign rem_next = fits ? diff[WIDTH-1:0] : shifted[WIDTH-1:0];
    assign quo_next = {quo_q[WIDTH-2:0], fits};

    assign last_step = running && (count == '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            done    <= 1'b0;
            count   <= CNT_W'(WIDTH - 1);
        end else if (running) begin
            if (last_step) begin
                running <= 1'b0;
                done    <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            quo_q     <= mag_dvd;
            rem_q     <= '0;
            dvs_q     <= mag_dvs;
            // Truncation toward zero
            neg_quo_q <= neg_dvd ^ neg_dvs;
            // Remainder follows the dividend
            neg_rem_q <= neg_dvd;
        end else if (running) begin
            if (last_step) begin
                quo_q <= neg_quo_q ? -quo_next : quo_next;
                rem_q <= neg_rem_q ? -rem_next : rem_next;
            end else begin
                quo_q <= quo_next;
                rem_q <= rem_next;
            end
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

// File: hw/rv32m_result.sv
// Combinational result stage of the RV32M unit
// Divide-by-zero and signed-overflow detection, unit start decode,
// busy generation and result word selection

module rv32m_result (
    input  logic                           start,
    input  rv32m_pkg::rv32m_op_t           op,
    input  logic                           new_req,
    input  rv32m_pkg::word_t               opa,
    input  rv32m_pkg::word_t               opb,
    input  logic                           sign_a,
    input  logic                           mul_done,
    input  logic [2*rv32m_pkg::XLEN-1:0]   product,
    input  logic                           div_done,
    input  rv32m_pkg::word_t               quotient,
    input  rv32m_pkg::word_t               remainder,
    output logic                           mul_start,
    output logic                           div_start,
    output logic                           busy,
    output rv32m_pkg::word_t               result
);

    logic is_div;
    logic div_zero;
    logic overflow;
    logic special;
    logic unit_done;

    assign is_div = op[2];

    assign div_zero = (opb == '0);
    // Only signed division can overflow
    assign overflow = sign_a && (opa == rv32m_pkg::SIGNED_MIN) && (opb == '1);

    // Answered here without running the divider
    assign special = is_div && (div_zero || overflow);

    assign mul_start = new_req && !is_div;
    assign div_start = new_req && is_div && !special;

    // Done flag of the unit serving this class
    assign unit_done = is_div ? div_done : mul_done;

    // Missing done flag counts as busy
    // Also covers the reset state
    assign busy = start && (new_req || (!special && !unit_done));

    always_comb begin
        result = '0;
        if (start) begin
            case (op)
                rv32m_pkg::MUL:
                    result = product[rv32m_pkg::XLEN-1:0];
                rv32m_pkg::MULH, rv32m_pkg::MULHSU, rv32m_pkg::MULHU:
                    result = product[2*rv32m_pkg::XLEN-1:rv32m_pkg::XLEN];
                rv32m_pkg::DIV, rv32m_pkg::DIVU: begin
                    if (div_zero)
                        result = rv32m_pkg::DIV_ZERO_QUOTIENT;
                    else if (overflow)
                        result = rv32m_pkg::SIGNED_MIN;
                    else
                        result = quotient;
                end
                // REM and REMU return the dividend on divide by zero
                default: begin
                    if (div_zero)
                        result = opa;
                    else if (overflow)
                        result = '0;
                    else
                        result = remainder;
                end
            endcase
        end
    end

endmodule

// File: hw/rv32m_unit.sv
// RV32M multiply/divide execute unit, top level
// Request stage, shift-add multiplier, restoring divider and result stage
// Start/busy handshake toward the requester

module rv32m_unit (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 start,
    input  rv32m_pkg::rv32m_op_t op,
    input  rv32m_pkg::word_t     a,
    input  rv32m_pkg::word_t     b,
    output logic                 busy,
    output rv32m_pkg::word_t     result
);

    // Datapath width for both arithmetic units
    localparam int WIDTH = rv32m_pkg::XLEN;

    // Request stage outputs
    logic                 new_req;
    rv32m_pkg::word_t     opa;
    rv32m_pkg::word_t     opb;
    logic                 sign_a;
    logic                 sign_b;

    // Multiplier
    logic                 mul_start;
    logic                 mul_done;
    logic [2*WIDTH-1:0]   product;

    // Divider
    logic                 div_start;
    logic                 div_done;
    rv32m_pkg::word_t     quotient;
    rv32m_pkg::word_t     remainder;

    rv32m_request i_request (
        .CLK     (CLK),
        .nRST    (nRST),
        .start   (start),
        .op      (op),
        .a       (a),
        .b       (b),
        .new_req (new_req),
        .opa     (opa),
        .opb     (opb),
        .sign_a  (sign_a),
        .sign_b  (sign_b)
    );

    shift_add_mul32 #(
        .WIDTH (WIDTH)
    ) i_mul (
        .CLK          (CLK),
        .nRST         (nRST),
        .start        (mul_start),
        .multiplicand (opa),
        .multiplier   (opb),
        .sign_a       (sign_a),
        .sign_b       (sign_b),
        .done         (mul_done),
        .product      (product)
    );

    // Division signedness is the same for both operands
    restoring_div32 #(
        .WIDTH (WIDTH)
    ) i_div (
        .CLK       (CLK),
        .nRST      (nRST),
        .start     (div_start),
        .dividend  (opa),
        .divisor   (opb),
        .is_signed (sign_a),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    rv32m_result i_result (
        .start     (start),
        .op        (op),
        .new_req   (new_req),
        .opa       (opa),
        .opb       (opb),
        .sign_a    (sign_a),
        .mul_done  (mul_done),
        .product   (product),
        .div_done  (div_done),
        .quotient  (quotient),
        .remainder (remainder),
        .mul_start (mul_start),
        .div_start (div_start),
        .busy      (busy),
        .result    (result)
    );

endmodule

// File: dv/rv32m_tb.sv
// Self-checking testbench for the RV32M multiply/divide unit
// Reference model of the M operations, random and directed requests,
// concurrent result checks, busy cycle checks and a watchdog

module rv32m_tb;

    localparam int W          = rv32m_pkg::XLEN;
    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 8;
    // Random requests for all eight operations plus the directed ones
    localparam int N_REQ      = 8 * N_RAND + 15;
    // Worst request is 34 cycles and each one is allowed 40
    localparam int TIMEOUT    = (N_REQ * 40 + 100) * CLK_PERIOD;

    logic                 CLK;
    logic                 nRST;
    logic                 start;
    rv32m_pkg::rv32m_op_t op;
    rv32m_pkg::word_t     a;
    rv32m_pkg::word_t     b;
    logic                 busy;
    rv32m_pkg::word_t     result;

    // Expected word for the request on the bus
    rv32m_pkg::word_t     exp_result;
    string                test_name;

    // Last request the unit saw with start high
    rv32m_pkg::rv32m_op_t last_op;
    rv32m_pkg::word_t     last_a;
    rv32m_pkg::word_t     last_b;
    logic                 last_valid;

    int                   seed;

    rv32m_unit i_dut (
        .CLK    (CLK),
        .nRST   (nRST),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .result (result)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Checked mid-cycle while the inputs are stable
    a_result: assert property (@(negedge CLK) disable iff (!nRST)
        (start && !busy) |-> (result == exp_result))
    else begin
        $display("ERR %s expected %h actual %h", test_name, exp_result, result);
        $display("TEST FAILED");
        $fatal(1);
    end

    // Idle bus gives zero busy and zero result
    a_idle: assert property (@(negedge CLK) disable iff (!nRST)
        !start |-> ((busy == 1'b0) && (result == '0)))
    else begin
        $display("ERR %s expected busy 0 result %h actual busy %b result %h",
                 test_name, {W{1'b0}}, busy, result);
        $display("TEST FAILED");
        $fatal(1);
    end

    // RISC-V M rules on 64-bit values
    task automatic compute_expected(input rv32m_pkg::rv32m_op_t o,
                                    input rv32m_pkg::word_t x,
                                    input rv32m_pkg::word_t y,
                                    output rv32m_pkg::word_t res);
        logic [2*W-1:0] xs;
        logic [2*W-1:0] xu;
        logic [2*W-1:0] ys;
        logic [2*W-1:0] yu;
        logic [2*W-1:0] prod;
        longint         q;
        xs = {{W{x[W-1]}}, x};
        xu = {{W{1'b0}}, x};
        ys = {{W{y[W-1]}}, y};
        yu = {{W{1'b0}}, y};
        res = '0;
        case (o)
            rv32m_pkg::MUL: begin
                prod = xs * ys;
                res  = prod[W-1:0];
            end
            rv32m_pkg::MULH: begin
                prod = xs * ys;
                res  = prod[2*W-1:W];
            end
            rv32m_pkg::MULHSU: begin
                prod = xs * yu;
                res  = prod[2*W-1:W];
            end
            rv32m_pkg::MULHU: begin
                prod = xu * yu;
                res  = prod[2*W-1:W];
            end
            rv32m_pkg::DIV: begin
                if (y == '0) begin
                    res = '1;
                end else if ((x == {1'b1, {(W-1){1'b0}}}) && (y == '1)) begin
                    res = x;
                end else begin
                    // Signed 64-bit divide truncates toward zero
                    q   = $signed(xs) / $signed(ys);
                    res = q[W-1:0];
                end
            end
            rv32m_pkg::DIVU: begin
                prod = (y == '0) ? '1 : xu / yu;
                res  = prod[W-1:0];
            end
            rv32m_pkg::REM: begin
                if (y == '0) begin
                    res = x;
                end else if ((x == {1'b1, {(W-1){1'b0}}}) && (y == '1)) begin
                    res = '0;
                end else begin
                    q   = $signed(xs) % $signed(ys);
                    res = q[W-1:0];
                end
            end
            default: begin
                prod = (y == '0) ? xu : xu % yu;
                res  = prod[W-1:0];
            end
        endcase
    endtask

    // Busy cycles from the handshake timing rules
    function automatic int expected_busy(input rv32m_pkg::rv32m_op_t o,
                                         input rv32m_pkg::word_t x,
                                         input rv32m_pkg::word_t y);
        logic sgn;
        sgn = (o == rv32m_pkg::DIV) || (o == rv32m_pkg::REM);
        if (last_valid && (o == last_op) && (x == last_a) && (y == last_b))
            return 0;
        if (o[2] && ((y == '0) || (sgn && (x == {1'b1, {(W-1){1'b0}}}) && (y == '1))))
            return 1;
        return 33;
    endfunction

    // One request held until the result is taken
    task automatic run_req(input string name, input rv32m_pkg::rv32m_op_t o,
                           input rv32m_pkg::word_t x, input rv32m_pkg::word_t y);
        rv32m_pkg::word_t expv;
        int               exp_cnt;
        int               cnt;
        compute_expected(o, x, y, expv);
        exp_cnt = expected_busy(o, x, y);
        @(posedge CLK);
        start      <= 1'b1;
        op         <= o;
        a          <= x;
        b          <= y;
        exp_result <= expv;
        test_name  <= $sformatf("%s %s", name, o.name());
        cnt = 0;
        @(negedge CLK);
        while (busy) begin
            cnt++;
            @(negedge CLK);
        end
        assert (cnt == exp_cnt)
        else begin
            $display("ERR %s %s busy cycles expected %0d actual %0d",
                     name, o.name(), exp_cnt, cnt);
            $display("TEST FAILED");
            $fatal(1);
        end
        last_op    = o;
        last_a     = x;
        last_b     = y;
        last_valid = 1'b1;
    endtask

    task automatic drop_start(input int cycles);
        @(posedge CLK);
        start     <= 1'b0;
        test_name <= "idle";
        repeat (cycles) @(posedge CLK);
    endtask

    initial begin
        rv32m_pkg::word_t x;
        rv32m_pkg::word_t y;
        seed       = 32'h6232fc2f;
        nRST       = 1'b0;
        start      = 1'b0;
        op         = rv32m_pkg::MUL;
        a          = '0;
        b          = '0;
        exp_result = '0;
        test_name  = "reset_idle";
        last_op    = rv32m_pkg::MUL;
        last_a     = '0;
        last_b     = '0;
        last_valid = 1'b0;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        // Idle bus after reset
        repeat (4) @(posedge CLK);

        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < N_RAND; i++) begin
                x = $random(seed);
                y = $random(seed);
                run_req("mul_random", rv32m_pkg::rv32m_op_t'(k[2:0]), x, y);
            end
        end

        for (int k = 4; k < 8; k++) begin
            for (int i = 0; i < N_RAND; i++) begin
                x = $random(seed);
                y = $random(seed);
                // Small signed divisor for a wide quotient
                if (i[0])
                    y = {{(W-16){y[15]}}, y[15:0]};
                run_req("div_random", rv32m_pkg::rv32m_op_t'(k[2:0]), x, y);
            end
        end

        // Divide by zero and signed overflow
        x = $random(seed);
        run_req("div_by_zero", rv32m_pkg::DIV, x, '0);
        run_req("div_by_zero", rv32m_pkg::DIVU, x, '0);
        run_req("div_by_zero", rv32m_pkg::REM, x, '0);
        run_req("div_by_zero", rv32m_pkg::REMU, x, '0);
        run_req("div_overflow", rv32m_pkg::DIV, {1'b1, {(W-1){1'b0}}}, '1);
        run_req("div_overflow", rv32m_pkg::REM, {1'b1, {(W-1){1'b0}}}, '1);
        drop_start(2);

        // Repeated requests answered from the held result
        x = $random(seed);
        y = $random(seed);
        run_req("repeat_base", rv32m_pkg::MUL, x, y);
        run_req("repeat_held", rv32m_pkg::MUL, x, y);
        drop_start(3);
        run_req("repeat_after_drop", rv32m_pkg::MUL, x, y);
        run_req("op_change", rv32m_pkg::MULH, x, y);
        run_req("repeat_base", rv32m_pkg::REM, x, y);
        drop_start(2);
        run_req("repeat_after_drop", rv32m_pkg::REM, x, y);
        run_req("op_change", rv32m_pkg::DIV, x, y);
        run_req("repeat_held", rv32m_pkg::DIV, x, y);
        drop_start(4);

        $display("TEST PASSED");
        $finish;
    end

    // Hang guard
    initial begin
        #(TIMEOUT);
        $display("Watchdog expired, the unit never dropped busy and the run hung");
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

// File: tb.f
common/rv32m_pkg.sv
hw/rv32m_request.sv
hw/mul/shift_add_mul32.sv
hw/div/restoring_div32.sv
hw/rv32m_result.sv
hw/rv32m_unit.sv
dv/rv32m_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RV32M testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv32m_tb \
    -f tb.f --Mdir obj_dir -o rv32m_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/rv32m_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
